/* bench/i2c_rtc_tb.sv */
`timescale 1ns/1ps

module i2c_rtc_tb;
	import rtc_pkg::*;

	localparam int TIMEOUT = 20000;	// Cycles per wait
	localparam int QUIET   = 2500;	// Window for a stray rtc_strb

	logic        clk;
	logic        reset;
	logic        strb_500ms;
	logic        wr_rtc_strb;
	logic [31:0] wreg_rtc_01;
	logic [23:0] wreg_rtc_02;
	logic [31:0] rtc_01;
	logic [23:0] rtc_02;
	logic        rtc_strb;
	logic        rtc_status;
	logic        scl_out;
	logic        sda_out;
	logic        ack_en;
	wire         sda_model;
	wire         scl_line;
	wire         sda_line;

	int          error_count = 0;
	int          check_count = 0;
	int          strb_count  = 0;
	logic        check_data  = 1'b0;	// Checker compares the words when set
	logic [31:0] exp_01      = '0;
	logic [23:0] exp_02      = '0;
	logic [55:0] wr_word;
	logic [55:0] shift_word;

	assign scl_line = scl_out;				// Only the master drives SCL
	assign sda_line = sda_out & sda_model;	// Wired AND

	i2c_rtc i_dut
	(
		.clk         (clk),
		.reset       (reset),
		.strb_500ms  (strb_500ms),
		.wr_rtc_strb (wr_rtc_strb),
		.wreg_rtc_01 (wreg_rtc_01),
		.wreg_rtc_02 (wreg_rtc_02),
		.scl_in      (scl_line),
		.sda_in      (sda_line),
		.rtc_01      (rtc_01),
		.rtc_02      (rtc_02),
		.rtc_strb    (rtc_strb),
		.rtc_status  (rtc_status),
		.scl_out     (scl_out),
		.sda_out     (sda_out)
	);

	isl1208_model i_model
	(
		.scl       (scl_line),
		.sda       (sda_line),
		.ack_en    (ack_en),
		.sda_drive (sda_model)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#2 clk = ~clk;
	end

	// --------------------
	// Helpers
	// --------------------

	// Expected time words from the slave registers with sc in the top byte
	function automatic logic [55:0] pack_rtc();
		logic [55:0] w;
		w = '0;
		for (int i = 0; i < RTC_BYTES; i++)
			w = {w[47:0], i_model.regs[i]};
		return w;
	endfunction

	task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
		check_count++;
		if (got !== exp)
		begin
			error_count++;
			$display("[ERROR] %s got %0h expected %0h", name, got, exp);
		end
	endtask

	task automatic finish_run();
		$display("checks %0d errors %0d strobes %0d", check_count, error_count, strb_count);
		if (error_count == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	endtask

	task automatic set_expected(input logic [55:0] w);
		exp_01     = w[55:24];
		exp_02     = w[23:0];
		check_data = 1'b1;
	endtask

	task automatic load_random_regs();
		for (int i = 0; i < RTC_BYTES; i++)
			i_model.regs[i] = $urandom % 256;
	endtask

	task automatic pulse_500ms();
		strb_500ms = 1'b1;
		@(negedge clk);
		strb_500ms = 1'b0;
	endtask

	// Wait until rtc_strb has been seen more than base times
	task automatic wait_strobe(input int base);
		int n;
		n = 0;
		while (strb_count == base && n < TIMEOUT)
		begin
			@(posedge clk);
			n++;
		end
		if (strb_count == base)
		begin
			$display("Timeout: no rtc_strb within %0d cycles", TIMEOUT);
			error_count++;
			finish_run();
		end
		else
			@(negedge clk);
	endtask

	task automatic expect_strobes(input int total);
		repeat (QUIET)
			@(posedge clk);
		compare("rtc_strb count", strb_count, total);
		@(negedge clk);
	endtask

	// Checker compares both words at each rtc_strb
	always @(negedge clk)
	begin
		if (rtc_strb === 1'b1)
		begin
			strb_count++;
			if (check_data)
			begin
				compare("rtc_01", rtc_01, exp_01);
				compare("rtc_02", rtc_02, exp_02);
			end
		end
	end

	// --------------------
	// Stimulus
	// --------------------
	initial
	begin
		void'($urandom(32'hdc4df2b1));
		reset       = 1'b1;
		strb_500ms  = 1'b0;
		wr_rtc_strb = 1'b0;
		wreg_rtc_01 = '0;
		wreg_rtc_02 = '0;
		ack_en      = 1'b1;
		repeat (2)
			@(negedge clk);
		reset = 1'b0;
		@(negedge clk);

		// Reset state
		compare("rtc_01", rtc_01, 0);
		compare("rtc_02", rtc_02, 0);
		compare("rtc_strb", rtc_strb, 0);
		compare("rtc_status", rtc_status, 0);
		compare("scl_out", scl_out, 1);
		compare("sda_out", sda_out, 1);

		// Plain read of random registers
		load_random_regs();
		set_expected(pack_rtc());
		pulse_500ms();
		wait_strobe(0);
		expect_strobes(1);
		compare("rtc_status", rtc_status, 0);

		// Write request leaves the words at the last read
		wreg_rtc_01 = $urandom;
		wreg_rtc_02 = $urandom % (1 << 24);
		wr_word     = {wreg_rtc_01, wreg_rtc_02};
		wr_rtc_strb = 1'b1;
		@(negedge clk);
		wr_rtc_strb = 1'b0;
		pulse_500ms();
		wait_strobe(1);
		shift_word = wr_word;
		for (int i = 0; i < RTC_BYTES; i++)
		begin
			compare($sformatf("regs[%0d]", i), i_model.regs[i], shift_word[55:48]);
			shift_word = shift_word << 8;
		end
		compare("regs[7]", i_model.regs[7], 8'h10);	// WRTC bit set

		// Next read returns the written time once the request is gone
		set_expected(wr_word);
		pulse_500ms();
		wait_strobe(2);
		expect_strobes(3);

		// Second strobe while a read runs
		load_random_regs();
		set_expected(pack_rtc());
		pulse_500ms();
		repeat (400)
			@(negedge clk);
		pulse_500ms();
		wait_strobe(3);
		expect_strobes(4);

		// No acks from the slave
		ack_en     = 1'b0;
		check_data = 1'b0;
		pulse_500ms();
		wait_strobe(4);
		compare("rtc_status", rtc_status, 1);
		ack_en = 1'b1;
		load_random_regs();
		set_expected(pack_rtc());
		pulse_500ms();
		wait_strobe(5);
		compare("rtc_status", rtc_status, 1);	// Sticky
		finish_run();
	end

endmodule

/* bench/isl1208_model.sv */
`timescale 1ns/1ps

// ISL1208 slave, time and status registers only
module isl1208_model
(
	input  logic scl,
	input  logic sda,			// Resolved bus line
	input  logic ack_en,		// 0 makes the slave ignore every transfer
	output logic sda_drive		// 0 pulls the line low
);
	import rtc_pkg::*;

	logic [7:0] regs [0:7];	// 0-6 time registers, 7 status
	logic [2:0] ptr;		// Register pointer, wraps at 8
	logic [7:0] shreg;		// Received byte
	logic [7:0] txd;		// Byte being sent
	logic [3:0] cnt;		// SCL rising edges in this byte
	logic       busy;		// Between start and stop or a lost address
	logic       first;		// Next byte is the address byte
	logic       rd_addr;	// R/W bit of the address
	logic       reading;	// Slave sends data
	logic       ptr_set;	// Pointer byte of a write taken
	logic       master_ack;

	initial
	begin
		sda_drive = 1'b1;
		busy      = 1'b0;
		ptr       = 3'd0;
		cnt       = 4'd0;
		for (int i = 0; i < 8; i++)
			regs[i] = 8'h00;
	end

	// --------------------
	// Start and stop
	// --------------------
	always @(negedge sda)
	begin
		if (scl === 1'b1)	// SDA falling with SCL high
		begin
			busy      <= 1'b1;
			first     <= 1'b1;
			reading   <= 1'b0;
			ptr_set   <= 1'b0;
			cnt       <= 4'd0;
			sda_drive <= 1'b1;
		end
	end

	always @(posedge sda)
	begin
		if (scl === 1'b1)
		begin
			busy    <= 1'b0;	// Stop
			reading <= 1'b0;
		end
	end

	// Sample on rising SCL
	always @(posedge scl)
	begin
		if (busy)
		begin
			cnt <= cnt + 4'd1;
			if (cnt < 4'd8)
				shreg <= {shreg[6:0], sda};
			else
				master_ack <= !sda;	// Ack slot of a read byte
		end
	end

	// --------------------
	// Drive on falling SCL
	// --------------------
	always @(negedge scl)
	begin
		if (busy && !reading)
		begin
			if (cnt == 4'd8 && first)
			begin
				if (shreg[7:1] == RTC_ADDR && ack_en)
				begin
					sda_drive <= 1'b0;	// Address ack
					rd_addr   <= shreg[0];
					first     <= 1'b0;
				end
				else
					busy <= 1'b0;	// Not for us, or acks disabled
			end
			else if (cnt == 4'd8)
			begin
				sda_drive <= 1'b0;
				if (!ptr_set)
				begin
					ptr     <= shreg[2:0];	// Register address
					ptr_set <= 1'b1;
				end
				else
				begin
					regs[ptr] <= shreg;
					ptr       <= ptr + 3'd1;
				end
			end
			else if (cnt == 4'd9)
			begin
				cnt <= 4'd0;
				if (rd_addr)
				begin
					reading   <= 1'b1;	// Read transfer, send first byte
					txd       <= regs[ptr];
					ptr       <= ptr + 3'd1;
					sda_drive <= regs[ptr][7];
				end
				else
					sda_drive <= 1'b1;	// Release after ack
			end
		end
		else if (busy)
		begin
			if (cnt >= 4'd1 && cnt <= 4'd7)
				sda_drive <= txd[3'd7 - cnt[2:0]];
			else if (cnt == 4'd8)
				sda_drive <= 1'b1;	// Master ack slot
			else if (cnt == 4'd9)
			begin
				cnt <= 4'd0;
				if (master_ack)
				begin
					txd       <= regs[ptr];
					ptr       <= ptr + 3'd1;
					sda_drive <= regs[ptr][7];
				end
				else
					busy <= 1'b0;	// Nack ends the read
			end
		end
	end

endmodule

/* i2c_rtc.f */
logic/rtc_pkg.sv
logic/i2c_byte_engine.sv
logic/rtc_sequencer.sv
logic/rtc_capture.sv
logic/i2c_rtc.sv
bench/isl1208_model.sv
bench/i2c_rtc_tb.sv

/* logic/i2c_byte_engine.sv */
`timescale 1ns/1ps

// Open-drain I2C master, one bus operation per command
module i2c_byte_engine
(
	input  logic       clk,
	input  logic       reset,
	input  logic       cmd_start,	// Start or repeated start
	input  logic       cmd_stop,	// Stop
	input  logic       cmd_tx,		// Write tx_byte, sample ack
	input  logic       cmd_rd,		// Read a byte, then ack or nack
	input  logic [7:0] tx_byte,
	input  logic       rx_nack,		// Nack the byte read by cmd_rd
	input  logic       scl_in,
	input  logic       sda_in,
	output logic       tx_cmplt,	// Start, stop or write finished
	output logic       strb_rx,		// Read finished
	output logic [7:0] rx_byte,
	output logic       tx_nack,		// Ack bit of the last write
	output logic       scl_out,		// 1 releases the line
	output logic       sda_out		// 1 releases the line
);
	import rtc_pkg::*;

	logic       busy;
	logic [1:0] op;			// 00 start, 01 stop, 10 write, 11 read
	logic [7:0] div_cnt;	// Quarter-bit divider
	logic [1:0] phase;		// Quarter within the bit
	logic [3:0] bit_cnt;	// 0-7 data, 8 ack slot
	logic [7:0] shreg;		// Shared tx/rx shift register
	logic       nack_hold;
	logic       scl_in_d;
	logic       tick;
	logic       scl_rise;
	logic       last_q;
	logic       bit_val;

	assign tick     = busy && (div_cnt == BAUD_DIV - 8'd1);
	assign scl_rise = scl_in && !scl_in_d;	// Data valid edge
	assign last_q   = (phase == 2'd3) && (!op[1] || bit_cnt == 4'd8);

	// Level put on SDA for the current bit
	always_comb
	begin
		if (op[0])
			bit_val = (bit_cnt == 4'd8) ? nack_hold : 1'b1;	// Read: release, then ack/nack
		else
			bit_val = (bit_cnt == 4'd8) ? 1'b1 : shreg[7];	// Write: MSB first, release for ack
	end

	// --------------------
	// Bus state machine
	// --------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy     <= 1'b0;
			op       <= 2'd0;
			div_cnt  <= 8'd0;
			phase    <= 2'd0;
			bit_cnt  <= 4'd0;
			scl_out  <= 1'b1;	// Bus released
			sda_out  <= 1'b1;
			tx_cmplt <= 1'b0;
			strb_rx  <= 1'b0;
		end
		else
		begin
			tx_cmplt <= 1'b0;
			strb_rx  <= 1'b0;
			if (!busy)
			begin
				div_cnt <= 8'd0;
				phase   <= 2'd0;
				bit_cnt <= 4'd0;
				if (cmd_start || cmd_stop || cmd_tx || cmd_rd)
				begin
					busy <= 1'b1;
					op   <= {cmd_tx | cmd_rd, cmd_stop | cmd_rd};
				end
			end
			else
			begin
				div_cnt <= tick ? 8'd0 : div_cnt + 8'd1;
				if (tick)
				begin
					phase <= phase + 2'd1;
					case (phase)
						2'd0:	// SCL low, set up SDA
						begin
							if (op == 2'd0)
								sda_out <= 1'b1;
							else if (op == 2'd1)
								sda_out <= 1'b0;
							else
								sda_out <= bit_val;
						end
						2'd1:
							scl_out <= 1'b1;	// Every operation raises SCL here
						2'd2:	// SCL high
						begin
							if (op == 2'd0)
								sda_out <= 1'b0;	// Start condition
							else if (op == 2'd1)
								sda_out <= 1'b1;	// Stop condition
						end
						default:
						begin
							if (op != 2'd1)
								scl_out <= 1'b0;	// Stop leaves the bus released
							if (op[1] && bit_cnt != 4'd8)
								bit_cnt <= bit_cnt + 4'd1;
						end
					endcase
					if (last_q)
					begin
						busy     <= 1'b0;
						tx_cmplt <= (op != 2'd3);
						strb_rx  <= (op == 2'd3);
					end
				end
			end
		end
	end

	// Edge detect on the SCL seen on the bus
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			scl_in_d <= 1'b1;
			tx_nack  <= 1'b0;
		end
		else
		begin
			scl_in_d <= scl_in;
			if (busy && op == 2'd2 && bit_cnt == 4'd8 && scl_rise)
				tx_nack <= sda_in;	// High means no ack from slave
		end
	end

	// Data path
	always_ff @(posedge clk)
	begin
		if (!busy && cmd_tx)
			shreg <= tx_byte;
		else if (busy && op == 2'd3 && bit_cnt != 4'd8 && scl_rise)
			shreg <= {shreg[6:0], sda_in};	// Shift in read data
		else if (tick && op == 2'd2 && phase == 2'd3 && bit_cnt != 4'd8)
			shreg <= {shreg[6:0], 1'b0};	// Next bit to MSB
		if (!busy && cmd_rd)
			nack_hold <= rx_nack;
		if (tick && op == 2'd3 && last_q)
			rx_byte <= shreg;
	end

endmodule

/* logic/i2c_rtc.sv */
`timescale 1ns/1ps

// ISL1208 time register mirror over I2C
module i2c_rtc
(
	input  logic        clk,
	input  logic        reset,
	input  logic        strb_500ms,
	input  logic        wr_rtc_strb,
	input  logic [31:0] wreg_rtc_01,	// sc, mn, hr, dt
	input  logic [23:0] wreg_rtc_02,	// mo, yr, dw
	input  logic        scl_in,
	input  logic        sda_in,
	output logic [31:0] rtc_01,
	output logic [23:0] rtc_02,
	output logic        rtc_strb,
	output logic        rtc_status,
	output logic        scl_out,		// Open drain, 1 releases
	output logic        sda_out
);
	import rtc_pkg::*;

	logic       cmd_start;
	logic       cmd_stop;
	logic       cmd_tx;
	logic       cmd_rd;
	logic [7:0] tx_byte;
	logic       rx_nack;
	logic       tx_cmplt;
	logic       strb_rx;
	logic [7:0] rx_byte;
	logic       tx_nack;
	logic       seq_start;
	logic       seq_done;

	// --------------------
	// Bus engine
	// --------------------
	i2c_byte_engine i_engine
	(
		.clk       (clk),
		.reset     (reset),
		.cmd_start (cmd_start),
		.cmd_stop  (cmd_stop),
		.cmd_tx    (cmd_tx),
		.cmd_rd    (cmd_rd),
		.tx_byte   (tx_byte),
		.rx_nack   (rx_nack),
		.scl_in    (scl_in),
		.sda_in    (sda_in),
		.tx_cmplt  (tx_cmplt),
		.strb_rx   (strb_rx),
		.rx_byte   (rx_byte),
		.tx_nack   (tx_nack),
		.scl_out   (scl_out),
		.sda_out   (sda_out)
	);

	// Read or write sequence per strobe
	rtc_sequencer i_seq
	(
		.clk         (clk),
		.reset       (reset),
		.strb_500ms  (strb_500ms),
		.wr_rtc_strb (wr_rtc_strb),
		.wreg_rtc_01 (wreg_rtc_01),
		.wreg_rtc_02 (wreg_rtc_02),
		.tx_cmplt    (tx_cmplt),
		.strb_rx     (strb_rx),
		.cmd_start   (cmd_start),
		.cmd_stop    (cmd_stop),
		.cmd_tx      (cmd_tx),
		.cmd_rd      (cmd_rd),
		.tx_byte     (tx_byte),
		.rx_nack     (rx_nack),
		.seq_start   (seq_start),
		.seq_done    (seq_done)
	);

	rtc_capture i_cap
	(
		.clk        (clk),
		.reset      (reset),
		.strb_rx    (strb_rx),
		.rx_byte    (rx_byte),
		.tx_cmplt   (tx_cmplt),
		.tx_nack    (tx_nack),
		.seq_start  (seq_start),
		.seq_done   (seq_done),
		.rtc_01     (rtc_01),
		.rtc_02     (rtc_02),
		.rtc_strb   (rtc_strb),
		.rtc_status (rtc_status)
	);

endmodule

/* logic/rtc_capture.sv */
`timescale 1ns/1ps

// Collects read bytes into the time words
module rtc_capture
(
	input  logic        clk,
	input  logic        reset,
	input  logic        strb_rx,
	input  logic [7:0]  rx_byte,
	input  logic        tx_cmplt,
	input  logic        tx_nack,
	input  logic        seq_start,
	input  logic        seq_done,
	output logic [31:0] rtc_01,		// sc, mn, hr, dt
	output logic [23:0] rtc_02,		// mo, yr, dw
	output logic        rtc_strb,	// New data ready
	output logic        rtc_status	// Sticky nack
);
	import rtc_pkg::*;

	logic [8*RTC_BYTES-1:0] time_word;	// sc in the top byte
	logic [2:0]             ptr;		// Index of the next read byte

	assign rtc_01 = time_word[55:24];
	assign rtc_02 = time_word[23:0];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			time_word  <= '0;
			ptr        <= 3'd0;
			rtc_strb   <= 1'b0;
			rtc_status <= 1'b0;
		end
		else
		begin
			rtc_strb <= seq_done;
			if (seq_start)
				ptr <= 3'd0;
			else if (strb_rx)
				ptr <= ptr + 3'd1;
			if (strb_rx && ptr < RTC_BYTES)
				time_word[8*(RTC_BYTES-1-ptr) +: 8] <= rx_byte;
			if (tx_cmplt && tx_nack)
				rtc_status <= 1'b1;	// Slave did not ack a write
		end
	end

endmodule

/* logic/rtc_pkg.sv */
// --------------------
// ISL1208 bus and register constants
// --------------------
package rtc_pkg;

	// Device address and register map
	localparam logic [6:0] RTC_ADDR = 7'h6F;	// 0xDE on write, 0xDF on read
	localparam logic [7:0] REG_SR   = 8'h07;	// Status register
	localparam logic [7:0] WRTC_SET = 8'h10;	// WRTC bit, unlocks the time registers
	localparam logic [7:0] REG_SC   = 8'h00;	// Seconds, first of the seven time registers

	// Bus timing
	// Clocks per quarter of an SCL period.
	// Small for simulation, a 250 kHz bus wants a much larger value
	localparam logic [7:0] BAUD_DIV = 8'd4;

	// Sequence lengths
	localparam int SEQ_W = 6;	// Step counter width

	// Read: S, DE, 00, Sr, DF, 7 x rd, P
	localparam logic [SEQ_W-1:0] READ_LAST = 6'd12;

	// Write: S DE 07 10 P, then S DE k d P for each register
	localparam logic [SEQ_W-1:0] WRITE_LAST = 6'd39;

	// sc, mn, hr, dt, mo, yr, dw
	localparam int RTC_BYTES = 7;

endpackage

/* logic/rtc_sequencer.sv */
`timescale 1ns/1ps

// Step sequencer for the RTC read and write sequences
module rtc_sequencer
(
	input  logic        clk,
	input  logic        reset,
	input  logic        strb_500ms,		// Starts one sequence when idle
	input  logic        wr_rtc_strb,	// Request a write of the time registers
	input  logic [31:0] wreg_rtc_01,	// sc, mn, hr, dt
	input  logic [23:0] wreg_rtc_02,	// mo, yr, dw
	input  logic        tx_cmplt,
	input  logic        strb_rx,
	output logic        cmd_start,
	output logic        cmd_stop,
	output logic        cmd_tx,
	output logic        cmd_rd,
	output logic [7:0]  tx_byte,
	output logic        rx_nack,
	output logic        seq_start,
	output logic        seq_done
);
	import rtc_pkg::*;

	logic                   req_pend;	// Write request waiting for the next strobe
	logic [8*RTC_BYTES-1:0] wr_word;	// sc..dw, high byte first
	logic                   active;
	logic                   wr_mode;
	logic [SEQ_W-1:0]       step;
	logic [SEQ_W-1:0]       last_step;
	logic                   launch;
	logic                   advance;
	logic                   fire;
	logic                   dec_mode;
	logic [SEQ_W-1:0]       dec_step;	// Step whose command is issued next
	logic [2:0]             pos;		// Place in a five-step write group
	logic [2:0]             grp;		// Group 0 is the WRTC write
	logic [2:0]             k;			// Time register index
	logic                   d_start;
	logic                   d_stop;
	logic                   d_tx;
	logic                   d_rd;
	logic                   d_nack;
	logic [7:0]             d_byte;

	assign last_step = wr_mode ? WRITE_LAST : READ_LAST;
	assign seq_done  = active && tx_cmplt && (step == last_step);	// Last stop done
	assign launch    = strb_500ms && !active;	// Strobes during a sequence are dropped
	assign advance   = active && (tx_cmplt || strb_rx) && (step != last_step);
	assign fire      = launch || advance;
	assign dec_mode  = launch ? req_pend : wr_mode;
	assign dec_step  = launch ? '0 : step + 1'b1;
	assign pos       = 3'(dec_step % 5);
	assign grp       = 3'(dec_step / 5);
	assign k         = grp - 3'd1;

	// --------------------
	// Step decode
	// --------------------
	always_comb
	begin
		d_start = 1'b0;
		d_stop  = 1'b0;
		d_tx    = 1'b0;
		d_rd    = 1'b0;
		d_nack  = 1'b0;
		d_byte  = 8'h00;
		if (dec_mode)
		begin
			case (pos)
				3'd0: d_start = 1'b1;
				3'd1:
				begin
					d_tx   = 1'b1;
					d_byte = {RTC_ADDR, 1'b0};	// 0xDE
				end
				3'd2:	// Register address
				begin
					d_tx = 1'b1;
					if (grp == 3'd0)
						d_byte = REG_SR;
					else
						d_byte = REG_SC + {5'd0, k};
				end
				3'd3:	// Register data
				begin
					d_tx = 1'b1;
					if (grp == 3'd0)
						d_byte = WRTC_SET;
					else
						d_byte = wr_word[8*(RTC_BYTES-1-k) +: 8];
				end
				default: d_stop = 1'b1;
			endcase
		end
		else
		begin
			case (dec_step)
				SEQ_W'(0), SEQ_W'(3): d_start = 1'b1;	// Start, repeated start
				SEQ_W'(1):
				begin
					d_tx   = 1'b1;
					d_byte = {RTC_ADDR, 1'b0};
				end
				SEQ_W'(2):
				begin
					d_tx   = 1'b1;
					d_byte = REG_SC;	// Pointer to seconds
				end
				SEQ_W'(4):
				begin
					d_tx   = 1'b1;
					d_byte = {RTC_ADDR, 1'b1};	// 0xDF
				end
				SEQ_W'(11):
				begin
					d_rd   = 1'b1;
					d_nack = 1'b1;	// Last byte, end the read
				end
				READ_LAST: d_stop = 1'b1;
				default: d_rd = 1'b1;	// Steps 5-10
			endcase
		end
	end

	// Request flag, mode, step counter and command strobes
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			req_pend  <= 1'b0;
			active    <= 1'b0;
			wr_mode   <= 1'b0;
			step      <= '0;
			cmd_start <= 1'b0;
			cmd_stop  <= 1'b0;
			cmd_tx    <= 1'b0;
			cmd_rd    <= 1'b0;
			seq_start <= 1'b0;
		end
		else
		begin
			cmd_start <= fire && d_start;
			cmd_stop  <= fire && d_stop;
			cmd_tx    <= fire && d_tx;
			cmd_rd    <= fire && d_rd;
			seq_start <= launch;
			if (wr_rtc_strb)
				req_pend <= 1'b1;
			else if (seq_done && wr_mode)
				req_pend <= 1'b0;	// Write sequence served the request
			if (launch)
			begin
				active  <= 1'b1;
				wr_mode <= req_pend;
				step    <= '0;
			end
			else if (seq_done)
				active <= 1'b0;
			else if (advance)
				step <= step + 1'b1;
		end
	end

	// Payload
	always_ff @(posedge clk)
	begin
		if (wr_rtc_strb)
			wr_word <= {wreg_rtc_01, wreg_rtc_02};
		if (fire)
		begin
			tx_byte <= d_byte;
			rx_nack <= d_nack;
		end
	end

endmodule
